/* source/pov_macros.svh */
`ifndef POV_MACROS_SVH
`define POV_MACROS_SVH

// panel geometry, one half of the HUB75 panel per slot
`define POV_NUM_ROWS  16 // pixels per column

// slots per turn step, slot i drives column i and column i+8
`define POV_SCAN_RATE 8

`define POV_NUM_COLS  16 // both halves together

// angle steps per revolution
`define POV_ROT_RES   64

// 3 bits each of red, green, blue
`define POV_RGB_RES   9

`endif

/* source/pov_pkg.sv */
`include "pov_macros.svh"

package pov_pkg;

    // one led, red in [8:6], green in [5:3], blue in [2:0]
    typedef logic [`POV_RGB_RES-1:0] pixel_t;

    // element 0 is row 0
    typedef pixel_t [`POV_NUM_ROWS-1:0] column_t;

    // [0] is slot i, [1] is slot i + scan rate
    typedef column_t [1:0] column_pair_t;

    typedef logic [$clog2(`POV_SCAN_RATE)-1:0] slot_t; // 0..7
    typedef logic [$clog2(`POV_ROT_RES)-1:0] theta_t; // current angle step

    // image rules, all closed form
    typedef enum logic [1:0] {
        mode_cylinder = 2'd0, // flat colour from angle
        mode_sphere   = 2'd1, // filled disc
        mode_cube     = 2'd2, // square outline
        mode_stripes  = 2'd3  // diagonal bands that rotate
    } mode_e;

endpackage

/* source/pov_ifs.sv */
`timescale 1ns/1ps

// decode -> execute request, strobe only, no ready
interface scan_req_if;
    logic              valid;   // one cycle per ready edge
    pov_pkg::slot_t    slot;
    pov_pkg::mode_e    mode;
    pov_pkg::theta_t   theta;
    logic              visible; // slot refreshed at this angle

    modport source (output valid, slot, mode, theta, visible);
    modport sink   (input  valid, slot, mode, theta, visible);
endinterface

// execute -> result, rendered pair
interface col_res_if;
    logic                  valid;
    logic                  visible;
    pov_pkg::slot_t        slot;
    pov_pkg::column_pair_t columns;

    modport source (output valid, visible, slot, columns);
    modport sink   (input  valid, visible, slot, columns);
endinterface

/* source/col_visibility.sv */
`timescale 1ns/1ps
`include "pov_macros.svh"

// scanline thinning for the inner part of the disc
// near the hub a column sweeps a short arc, so every other angle step is enough
module col_visibility (
    input  pov_pkg::slot_t  slot,
    input  pov_pkg::theta_t theta,
    output logic            visible
);

    localparam int HALF = `POV_SCAN_RATE / 2; // first outer slot

    logic outer;      // slots 4..7, far from the hub
    logic parity_hit; // inner slot whose turn it is

    // outer slots always refresh
    assign outer = (int'(slot) >= HALF);

    // inner slots interleave, even slots on even angles and odd on odd
    assign parity_hit = (theta[0] == slot[0]);

    assign visible = outer | parity_hit;

endmodule

/* source/scan_sequencer.sv */
`timescale 1ns/1ps
`include "pov_macros.svh"

// decode stage
// one request per rising edge of hub75_ready, slot counter walks 0..7
module scan_sequencer (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             hub75_ready,
    input  pov_pkg::mode_e   mode,
    input  pov_pkg::theta_t  dtheta,
    scan_req_if.source       req
);

    logic           ready_q;   // hub75_ready one cycle ago
    logic           ready_rise;
    pov_pkg::slot_t slot_cnt;  // next slot to issue
    logic           slot_vis;  // visibility of slot_cnt at dtheta

    // edge, ready may stay high for several cycles
    assign ready_rise = hub75_ready & ~ready_q;

    // rule lives in its own block
    col_visibility u_col_visibility (
        .slot    (slot_cnt),
        .theta   (dtheta),
        .visible (slot_vis)
    );

    // control side
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ready_q   <= 1'b0;
            slot_cnt  <= '0; // first request uses slot 0
            req.valid <= 1'b0;
        end else begin
            ready_q   <= hub75_ready;
            req.valid <= ready_rise; // single cycle strobe
            if (ready_rise) begin
                // wraps modulo scan rate
                if (int'(slot_cnt) == `POV_SCAN_RATE - 1) begin
                    slot_cnt <= '0;
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end
        end
    end

    // request payload, captured with the edge
    always_ff @(posedge clk_in) begin
        if (ready_rise) begin
            req.slot    <= slot_cnt;
            req.mode    <= mode;    // mode sampled same cycle
            req.theta   <= dtheta;
            req.visible <= slot_vis;
        end
    end

endmodule

/* source/pattern_engine.sv */
`timescale 1ns/1ps
`include "pov_macros.svh"

// execute stage
// renders both columns of the pair from the mode rule, one cycle latency
module pattern_engine (
    input  logic       clk_in,
    input  logic       rst_in,
    scan_req_if.sink   req,
    col_res_if.source  res
);

    localparam int ROW_W   = $clog2(`POV_NUM_ROWS);
    localparam int COL_W   = $clog2(`POV_NUM_COLS);
    localparam int RADIUS2 = `POV_NUM_ROWS * `POV_NUM_ROWS; // (2r)^2, doubled coords
    localparam int EDGE_LO = 2;                 // cube outline, first ring
    localparam int EDGE_HI = `POV_NUM_COLS - 3; // and last

    pov_pkg::column_pair_t cols_d; // rendered pair, combinational

    // one pixel at column x, row y
    function automatic pov_pkg::pixel_t render_pixel(
        input pov_pkg::mode_e  m,
        input logic [COL_W-1:0] x,
        input logic [ROW_W-1:0] y,
        input pov_pkg::theta_t th
    );
        int              dx;     // doubled offset from centre
        int              dy;
        int              xi;
        int              yi;
        logic            rim_y;  // on top or bottom edge
        logic            rim_x;  // on left or right edge
        logic [1:0]      phase;  // stripe position mod 4
        pov_pkg::pixel_t pix;

        xi = int'(x);
        yi = int'(y);
        // centre sits between pixels 7 and 8, so work in doubled units
        dx = 2 * xi - (`POV_NUM_COLS - 1);
        dy = 2 * yi - (`POV_NUM_ROWS - 1);
        rim_y = ((yi == EDGE_LO) || (yi == EDGE_HI)) && (xi >= EDGE_LO) && (xi <= EDGE_HI);
        rim_x = ((xi == EDGE_LO) || (xi == EDGE_HI)) && (yi >= EDGE_LO) && (yi <= EDGE_HI);
        phase = x[1:0] + y[1:0] + th[1:0]; // 2 bit add wraps mod 4
        pix   = '0;

        case (m)
            pov_pkg::mode_cylinder: begin
                pix = {th[5:3], 3'b111, th[2:0]}; // hue follows the angle
            end
            pov_pkg::mode_sphere: begin
                if (dx * dx + dy * dy <= RADIUS2) begin
                    pix = 9'h1FF; // white
                end
            end
            pov_pkg::mode_cube: begin
                if (rim_x || rim_y) begin
                    pix = 9'o700; // red
                end
            end
            pov_pkg::mode_stripes: begin
                if (phase == 2'd0) begin
                    pix = 9'o070; // green
                end
            end
            default: pix = '0;
        endcase
        return pix;
    endfunction

    // c = 0 is column i, c = 1 is column i + scan rate
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            for (int y = 0; y < `POV_NUM_ROWS; y++) begin
                cols_d[c][y] = render_pixel(
                    req.mode,
                    COL_W'(req.slot) + COL_W'(c * `POV_SCAN_RATE),
                    y[ROW_W-1:0],
                    req.theta
                );
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= req.valid; // strobe follows request
        end
    end

    // payload only moves on a request
    always_ff @(posedge clk_in) begin
        if (req.valid) begin
            res.columns <= cols_d;
            res.visible <= req.visible; // tested downstream
            res.slot    <= req.slot;
        end
    end

endmodule

/* source/column_output.sv */
`timescale 1ns/1ps
`include "pov_macros.svh"

// result stage
// data_valid pulses for every result, data only changes for visible ones
module column_output (
    input  logic                          clk_in,
    input  logic                          rst_in,
    col_res_if.sink                       res,
    output pov_pkg::column_pair_t         columns,
    output pov_pkg::slot_t                col_num1,
    output logic [$clog2(`POV_NUM_COLS)-1:0] col_num2,
    output logic                          data_valid
);

    localparam int NUM_W = $clog2(`POV_NUM_COLS);

    logic load; // visible result arriving

    assign load = res.valid & res.visible;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            data_valid <= 1'b0;
            columns    <= '0;
            col_num1   <= '0;
            col_num2   <= NUM_W'(`POV_SCAN_RATE); // lower half of slot 0
        end else begin
            data_valid <= res.valid; // one cycle, invisible too
            if (load) begin
                columns  <= res.columns;
                col_num1 <= res.slot;
                // partner column, loaded with col_num1 so they never disagree
                col_num2 <= NUM_W'(res.slot) + NUM_W'(`POV_SCAN_RATE);
            end
        end
    end

endmodule

/* source/pov_frame_top.sv */
`timescale 1ns/1ps
`include "pov_macros.svh"

// pov column feeder
// decode -> execute -> result, three cycles from ready edge to data_valid
module pov_frame_top (
    input  logic                                             clk_in,
    input  logic                                             rst_in,
    input  logic [1:0]                                       mode,
    input  logic [$clog2(`POV_ROT_RES)-1:0]                  dtheta,
    input  logic                                             hub75_ready,
    output logic [2*`POV_NUM_ROWS*`POV_RGB_RES-1:0]          columns,
    output logic [$clog2(`POV_SCAN_RATE)-1:0]                col_num1,
    output logic [$clog2(`POV_NUM_COLS)-1:0]                 col_num2,
    output logic                                             data_valid
);

    pov_pkg::column_pair_t cols_out; // typed view of the columns port
    pov_pkg::mode_e        mode_in;

    assign mode_in = pov_pkg::mode_e'(mode); // all 4 codes are legal
    assign columns = cols_out;              // same packed width

    scan_req_if req_if ();
    col_res_if  res_if ();

    scan_sequencer u_scan_sequencer (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .hub75_ready (hub75_ready),
        .mode        (mode_in),
        .dtheta      (dtheta),
        .req         (req_if.source)
    );

    pattern_engine u_pattern_engine (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .req    (req_if.sink),
        .res    (res_if.source)
    );

    column_output u_column_output (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .res        (res_if.sink),
        .columns    (cols_out),
        .col_num1   (col_num1),
        .col_num2   (col_num2),
        .data_valid (data_valid)
    );

endmodule

/* bench/pov_frame_checker.sv */
`timescale 1ns/1ps
`include "pov_macros.svh"

// protocol checks on the top-level ports of the column feeder
module pov_frame_checker (
    input logic                                    clk_in,
    input logic                                    rst_in,
    input logic                                    hub75_ready,
    input logic [2*`POV_NUM_ROWS*`POV_RGB_RES-1:0] columns,
    input logic [$clog2(`POV_SCAN_RATE)-1:0]       col_num1,
    input logic [$clog2(`POV_NUM_COLS)-1:0]        col_num2,
    input logic                                    data_valid
);

    // cycle after a reset edge shows the reset values
    a_reset_values: assert property (@(posedge clk_in)
        rst_in |=> (!data_valid && columns == '0 && col_num1 == '0 && col_num2 == 4'd8))
        else $error("outputs not at reset values after reset");

    // ready edge sampled at N, data_valid sampled high at N+3
    a_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(hub75_ready) |-> ##3 data_valid)
        else $error("data_valid missing 3 cycles after ready edge");

    a_single_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
        data_valid |=> !data_valid)
        else $error("data_valid high for more than one cycle");

    // no pulse without a ready edge behind it
    a_pulse_source: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(data_valid) |-> ($past(hub75_ready, 3) && !$past(hub75_ready, 4)))
        else $error("data_valid without a matching ready edge");

endmodule

bind pov_frame_top pov_frame_checker u_pov_frame_checker (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .hub75_ready (hub75_ready),
    .columns     (columns),
    .col_num1    (col_num1),
    .col_num2    (col_num2),
    .data_valid  (data_valid)
);

/* bench/pov_frame_tb.sv */
`timescale 1ns/1ps
`include "pov_macros.svh"

module pov_frame_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_TESTS   = 24;
    localparam int PAIR_W      = 2 * `POV_NUM_ROWS * `POV_RGB_RES;
    localparam int DV_WAIT     = 3;  // negedges from the sampled ready edge to data_valid
    localparam int DV_TIMEOUT  = 10; // cycles before a pulse counts as lost
    localparam int WATCHDOG_NS = NUM_TESTS * 8 * CLK_PERIOD + 1000;

    logic              clk_in;
    logic              rst_in;
    logic [1:0]        mode;
    logic [5:0]        dtheta;
    logic              hub75_ready;
    logic [PAIR_W-1:0] columns;
    logic [2:0]        col_num1;
    logic [3:0]        col_num2;
    logic              data_valid;

    // stimulus table
    string      names  [NUM_TESTS];
    logic [1:0] modes  [NUM_TESTS];
    logic [5:0] thetas [NUM_TESTS];

    // reference model state
    int                slot_model;  // next slot the DUT should use
    logic [PAIR_W-1:0] exp_cols;    // last visible pair
    logic [2:0]        exp_num1;
    logic [3:0]        exp_num2;

    int          tests_run;
    int          tests_failed;
    int          errors;
    int          test_err;    // errors in the running test

    pov_frame_top u_pov_frame_top (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .mode        (mode),
        .dtheta      (dtheta),
        .hub75_ready (hub75_ready),
        .columns     (columns),
        .col_num1    (col_num1),
        .col_num2    (col_num2),
        .data_valid  (data_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    // hard stop, 8 cycles per table entry plus margin
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    // image rules straight from the mode definitions
    function automatic logic [8:0] expected_pixel(input logic [1:0] m, input int x,
                                                  input int y, input logic [5:0] th);
        int         dx2;
        int         dy2;
        logic [8:0] p;
        dx2 = 2 * x - 15; // doubled distance from panel centre
        dy2 = 2 * y - 15;
        p   = 9'h000;
        case (m)
            2'd0: p = {th[5:3], 3'b111, th[2:0]};
            2'd1: if (dx2 * dx2 + dy2 * dy2 <= 256) p = 9'h1ff;
            2'd2: begin
                if (((y == 2 || y == 13) && x >= 2 && x <= 13) ||
                    ((x == 2 || x == 13) && y >= 2 && y <= 13)) p = 9'o700;
            end
            default: if ((x + y + int'(th)) % 4 == 0) p = 9'o070;
        endcase
        return p;
    endfunction

    function automatic logic [PAIR_W-1:0] expected_pair(input logic [1:0] m, input int slot,
                                                        input logic [5:0] th);
        logic [PAIR_W-1:0] v;
        v = '0;
        for (int c = 0; c < 2; c++) begin
            for (int y = 0; y < 16; y++) begin
                v[(c * 16 + y) * 9 +: 9] = expected_pixel(m, slot + c * 8, y, th); // c=1 lower half
            end
        end
        return v;
    endfunction

    task automatic set_entry(input int idx, input string name, input logic [1:0] m,
                             input logic [5:0] th);
        names[idx]  = name;
        modes[idx]  = m;
        thetas[idx] = th;
    endtask

    // entry i runs on slot i mod 8
    task automatic fill_table();
        set_entry(0,  "cyl_s0_t0",      2'd0, 6'd0);
        set_entry(1,  "cyl_s1_hidden",  2'd0, 6'd2);  // odd slot, even angle
        set_entry(2,  "sphere_s2",      2'd1, 6'd4);
        set_entry(3,  "sphere_s3",      2'd1, 6'd7);
        set_entry(4,  "cube_s4",        2'd2, 6'd0);
        set_entry(5,  "cube_s5",        2'd2, 6'd9);
        set_entry(6,  "stripes_s6_t1",  2'd3, 6'd1);
        set_entry(7,  "stripes_s7_t2",  2'd3, 6'd2);
        set_entry(8,  "cyl_s0_hidden",  2'd0, 6'd21); // even slot, odd angle
        set_entry(9,  "cyl_s1_t45",     2'd0, 6'd45);
        set_entry(10, "stripes_s2_t6",  2'd3, 6'd6);
        set_entry(11, "stripes_s3_t11", 2'd3, 6'd11);
        set_entry(12, "sphere_s4",      2'd1, 6'd33);
        set_entry(13, "cyl_s5_t63",     2'd0, 6'd63);
        set_entry(14, "cube_s6",        2'd2, 6'd12);
        set_entry(15, "sphere_s7",      2'd1, 6'd40);
        for (int i = 16; i < NUM_TESTS; i++) begin
            set_entry(i, $sformatf("rand_%0d", i), 2'($urandom_range(3, 0)), 6'($urandom));
        end
    endtask

    task automatic check_outputs(input string name);
        if (columns !== exp_cols) begin
            $display("mismatch %s columns expected %h actual %h", name, exp_cols, columns);
            test_err++;
        end
        if (col_num1 !== exp_num1) begin
            $display("mismatch %s col_num1 expected %0d actual %0d", name, exp_num1, col_num1);
            test_err++;
        end
        if (col_num2 !== exp_num2) begin
            $display("mismatch %s col_num2 expected %0d actual %0d", name, exp_num2, col_num2);
            test_err++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_err;
        if (test_err == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_err);
        end
    endtask

    task automatic run_entry(input int idx);
        int   n_wait;
        logic seen;
        logic vis;
        n_wait   = 0;
        seen     = 1'b0;
        test_err = 0;
        @(posedge clk_in);
        mode        <= modes[idx];
        dtheta      <= thetas[idx];
        hub75_ready <= 1'b1;
        @(posedge clk_in);
        hub75_ready <= 1'b0; // one cycle wide, DUT samples the edge here
        // outer slots always refresh, inner ones on matching parity
        vis = (slot_model >= 4) || ((slot_model % 2) == int'(thetas[idx][0]));
        if (vis) begin
            exp_cols = expected_pair(modes[idx], slot_model, thetas[idx]);
            exp_num1 = 3'(slot_model);
            exp_num2 = {1'b0, exp_num1} + 4'd8;
        end
        slot_model = (slot_model + 1) % 8;
        while (!seen && n_wait < DV_TIMEOUT) begin
            @(negedge clk_in);
            n_wait++;
            seen = data_valid;
        end
        if (!seen) begin
            $display("test %s: no data_valid pulse within %0d cycles of the ready edge",
                     names[idx], DV_TIMEOUT);
            test_err++;
        end else begin
            if (n_wait != DV_WAIT) begin
                $display("mismatch %s latency expected %0d actual %0d",
                         names[idx], DV_WAIT, n_wait);
                test_err++;
            end
            check_outputs(names[idx]);
            @(negedge clk_in);
            if (data_valid !== 1'b0) begin
                $display("mismatch %s data_valid after pulse expected 0 actual %b",
                         names[idx], data_valid);
                test_err++;
            end
        end
        finish_test(names[idx]);
    endtask

    initial begin
        void'($urandom(32'h33)); // seeds the generator for the run
        rst_in       = 1'b1;
        mode         = 2'd0;
        dtheta       = 6'd0;
        hub75_ready  = 1'b0;
        slot_model   = 0;
        exp_cols     = '0;
        exp_num1     = 3'd0;
        exp_num2     = 4'd8; // lower half of slot 0
        tests_run    = 0;
        tests_failed = 0;
        errors       = 0;
        test_err     = 0;
        fill_table();
        repeat (2) @(posedge clk_in);
        rst_in <= 1'b0;
        @(negedge clk_in);
        if (data_valid !== 1'b0) begin
            $display("mismatch reset data_valid expected 0 actual %b", data_valid);
            test_err++;
        end
        check_outputs("reset");
        finish_test("reset");
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+source
source/pov_pkg.sv
source/pov_ifs.sv
source/col_visibility.sv
source/scan_sequencer.sv
source/pattern_engine.sv
source/column_output.sv
source/pov_frame_top.sv
bench/pov_frame_checker.sv
bench/pov_frame_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := pov_frame_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
